/* testbench/pcs_patterns.txt */
// tx_word ctrl fault_mask(66b) exp_word exp_ctrl exp_valid exp_lock, one line per cycle
// Mask hits the word two lines up, both words are XORed with an LFSR word in the testbench
// Lock acquisition, 8 good headers
0000000000000000 0 00000000000000000 0000000000000000 0 0 0
ffffffffffffffff 1 00000000000000000 ffffffffffffffff 1 0 0
0123456789abcdef 0 00000000000000000 0123456789abcdef 0 0 0
fedcba9876543210 0 00000000000000000 fedcba9876543210 0 0 0
a5a5a5a5a5a5a5a5 1 00000000000000000 a5a5a5a5a5a5a5a5 1 0 0
5a5a5a5a5a5a5a5a 0 00000000000000000 5a5a5a5a5a5a5a5a 0 0 0
00000000ffffffff 0 00000000000000000 00000000ffffffff 0 0 0
ffffffff00000000 0 00000000000000000 ffffffff00000000 0 1 1
// Clean loopback
1e1e1e1e1e1e1e1e 1 00000000000000000 1e1e1e1e1e1e1e1e 1 1 1
8000000000000001 0 00000000000000000 8000000000000001 0 1 1
0f0f0f0f0f0f0f0f 0 00000000000000000 0f0f0f0f0f0f0f0f 0 1 1
dead0000beef0000 1 00000000000000000 dead0000beef0000 1 1 1
// Header fault on line 12, lock held
1111111111111111 1 00000000000000000 1111111111111111 0 0 1
2222222222222222 0 00000000000000000 2222222222222222 0 1 1
3333333333333333 0 00000000000000001 3333333333333333 0 1 1
4444444444444444 1 00000000000000000 4444444444444444 1 1 1
// Loss of lock, bad headers on lines 16 to 18
5555555555555555 0 00000000000000000 5555555555555555 0 0 1
6666666666666666 1 00000000000000000 6666666666666666 0 0 1
7777777777777777 0 00000000000000001 7777777777777777 0 0 0
8888888888888888 0 00000000000000001 8888888888888888 0 0 0
9999999999999999 0 00000000000000001 9999999999999999 0 0 0
aaaaaaaaaaaaaaaa 1 00000000000000000 aaaaaaaaaaaaaaaa 1 0 0
bbbbbbbbbbbbbbbb 0 00000000000000000 bbbbbbbbbbbbbbbb 0 0 0
cccccccccccccccc 0 00000000000000000 cccccccccccccccc 0 0 0
dddddddddddddddd 1 00000000000000000 dddddddddddddddd 1 0 0
eeeeeeeeeeeeeeee 0 00000000000000000 eeeeeeeeeeeeeeee 0 0 0
ffff0000ffff0000 1 00000000000000000 ffff0000ffff0000 1 1 1
0000ffff0000ffff 0 00000000000000000 0000ffff0000ffff 0 1 1
// Error multiplication, payload bit 10 of line 28 flipped
0000000000000000 0 00000000000000000 0002000000000400 0 1 1
0000000000000000 0 00000000000000000 0000000000000010 0 1 1
1234123412341234 0 00000000000001000 1234123412341234 0 1 1
4321432143214321 1 00000000000000000 4321432143214321 1 1 1
0badf00d0badf00d 0 00000000000000000 0badf00d0badf00d 0 1 1
c0ffee00c0ffee00 0 00000000000000000 c0ffee00c0ffee00 0 1 1

/* filelist.f */
design/pcs_pkg.sv
design/pcs_block_framer.sv
design/pcs_scrambler.sv
design/pcs_block_lock.sv
design/pcs_loopback.sv
testbench/pcs_loopback_assert.sv
testbench/pcs_loopback_tb.sv

/* Bender.yml */
package:
  name: pcs_loopback

sources:
  # Shared package
  - files:
      - design/pcs_pkg.sv
  # Design sources
  - files:
      - design/pcs_block_framer.sv
      - design/pcs_scrambler.sv
      - design/pcs_block_lock.sv
      - design/pcs_loopback.sv
  # Testbench sources
  - target: test
    files:
      - testbench/pcs_loopback_assert.sv
      - testbench/pcs_loopback_tb.sv

/* testbench/pcs_loopback_tb.sv */
// Testbench for the PCS loopback: clock, reset, pattern reader, LFSR payload, checks, watchdog
`timescale 1ns/100ps
`default_nettype none

module pcs_loopback_tb
	import pcs_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int LATENCY    = 4;
	localparam int MAX_LINES  = 128;

	// DUT connections
	logic       i_clk = 1'b0;
	logic       i_reset_n;
	pcs_word_t  tx_data;
	logic       tx_ctrl;
	pcs_block_t fault_mask;
	pcs_word_t  rx_data;
	rx_status_t rx_status;

	// Pattern table, one entry per cycle
	pcs_word_t  pat_word  [MAX_LINES];
	logic       pat_ctrl  [MAX_LINES];
	pcs_block_t pat_mask  [MAX_LINES];
	pcs_word_t  exp_word  [MAX_LINES];
	logic       exp_ctrl  [MAX_LINES];
	logic       exp_valid [MAX_LINES];
	logic       exp_lock  [MAX_LINES];
	// LFSR word mixed into both tx and expected words
	pcs_word_t  rnd_word  [MAX_LINES];
	int         num_lines = 0;
	logic [31:0] lfsr;

	pcs_loopback #(
		.LOCK_GOOD (8),
		.BAD_LIMIT (4)
	) pcs_loopback_i (
		.i_clk        (i_clk),
		.i_reset_n    (i_reset_n),
		.i_tx_data    (tx_data),
		.i_tx_ctrl    (tx_ctrl),
		.i_fault_mask (fault_mask),
		.o_rx_data    (rx_data),
		.o_rx_status  (rx_status)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Galois LFSR, shifts right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hB4BCD35C;
		return s >> 1;
	endfunction

	// One LFSR step per bit of the word
	task automatic draw_word(output pcs_word_t w);
		for (int b = 0; b < $bits(pcs_word_t); b++)
		begin
			w[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// Header as the receiver sees it, sent header flipped by the mask two lines later
	// A header is bad when both of its bits are equal
	function automatic logic expected_hdr_err(input int idx);
		pcs_hdr_t line_hdr;
		line_hdr = pat_ctrl[idx] ? SYNC_CTRL : SYNC_DATA;
		if (idx + 2 < num_lines)
			line_hdr = line_hdr ^ pat_mask[idx + 2][HDR_BITS-1:0];
		return line_hdr[1] == line_hdr[0];
	endfunction

	// Lines starting with // are skipped
	task automatic read_patterns();
		int         fd;
		int         rc;
		string      text;
		pcs_word_t  w;
		pcs_word_t  ew;
		pcs_block_t m;
		logic       c;
		logic       ec;
		logic       ev;
		logic       el;
		fd = $fopen("testbench/pcs_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Pattern file testbench/pcs_patterns.txt could not be opened");
			$display("CHECKS FAILED");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			text = "";
			rc = $fgets(text, fd);
			if (text.len() >= 2 && text.substr(0, 1) != "//")
			begin
				rc = $sscanf(text, "%h %h %h %h %h %h %h", w, c, m, ew, ec, ev, el);
				if (rc == 7 && num_lines < MAX_LINES)
				begin
					pat_word[num_lines]  = w;
					pat_ctrl[num_lines]  = c;
					pat_mask[num_lines]  = m;
					exp_word[num_lines]  = ew;
					exp_ctrl[num_lines]  = ec;
					exp_valid[num_lines] = ev;
					exp_lock[num_lines]  = el;
					draw_word(rnd_word[num_lines]);
					num_lines++;
				end
				else if (rc > 0)
				begin
					$display("Bad or surplus pattern line after entry %0d", num_lines);
					$display("CHECKS FAILED");
					$fatal(1);
				end
			end
		end
		$fclose(fd);
	endtask

	// Receive side of one pattern line, 4 clocks after it was driven
	task automatic check_line(input int idx);
		rx_status_t st;
		st = rx_status;
		compare($sformatf("line %0d rx_data", idx), exp_word[idx] ^ rnd_word[idx], rx_data);
		compare($sformatf("line %0d ctrl", idx), 64'(exp_ctrl[idx]), 64'(st.ctrl));
		compare($sformatf("line %0d valid", idx), 64'(exp_valid[idx]), 64'(st.valid));
		compare($sformatf("line %0d lock", idx), 64'(exp_lock[idx]), 64'(st.lock));
		compare($sformatf("line %0d hdr_err", idx), 64'(expected_hdr_err(idx)),
			64'(st.hdr_err));
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and checking
	////////////////////////////////////////////////////////////

	initial
	begin
		i_reset_n  = 1'b0;
		tx_data    = '0;
		tx_ctrl    = 1'b0;
		fault_mask = '0;
		lfsr       = 32'h5665;
		read_patterns();
		if (num_lines == 0)
		begin
			$display("Pattern file holds no pattern lines");
			$display("CHECKS FAILED");
			$fatal(1);
		end
		repeat (8) @(posedge i_clk);
		@(negedge i_clk);
		i_reset_n = 1'b1;
		// Check line n-4, then drive line n, all on the falling edge
		for (int n = 0; n < num_lines + LATENCY; n++)
		begin
			if (n >= LATENCY)
				check_line(n - LATENCY);
			if (n < num_lines)
			begin
				tx_data    = pat_word[n] ^ rnd_word[n];
				tx_ctrl    = pat_ctrl[n];
				fault_mask = pat_mask[n];
			end
			else
			begin
				tx_data    = '0;
				tx_ctrl    = 1'b0;
				fault_mask = '0;
			end
			@(negedge i_clk);
		end
		if (pcs_loopback_i.pcs_loopback_assert_i.assert_fails != 0)
		begin
			$display("Assertion failures seen during the run");
			$display("CHECKS FAILED");
			$fatal(1);
		end
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

	// Watchdog, pattern length plus room for reset and pipeline drain
	initial
	begin
		wait (num_lines > 0);
		#(CLK_PERIOD * (num_lines + 50));
		$display("Timeout, the run did not finish in time");
		$display("CHECKS FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* testbench/pcs_loopback_assert.sv */
// Concurrent assertions on valid, lock and header error of the PCS loopback, with bind
`timescale 1ns/100ps
`default_nettype none

module pcs_loopback_assert
	import pcs_pkg::*;
(
	input wire              i_clk,
	input wire              i_reset_n,
	input wire rx_status_t  i_rx_status,
	input wire pcs_block_t  i_rx_block
);

	// Failures seen so far, read by the testbench at the end
	int assert_fails = 0;

	// Header the lock stage saw, status shows it one clock later
	pcs_hdr_t hdr;
	assign hdr = i_rx_block[HDR_BITS-1:0];

	valid_needs_lock: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		i_rx_status.valid |-> i_rx_status.lock)
	else
	begin
		assert_fails++;
		$error("valid high without lock");
	end

	valid_not_hdr_err: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		!(i_rx_status.valid && i_rx_status.hdr_err))
	else
	begin
		assert_fails++;
		$error("valid and hdr_err high together");
	end

	hdr_err_only_bad: assert property (@(posedge i_clk) disable iff (!i_reset_n)
		i_rx_status.hdr_err |-> (($past(hdr) != SYNC_DATA) && ($past(hdr) != SYNC_CTRL)))
	else
	begin
		assert_fails++;
		$error("hdr_err on a valid sync header");
	end

endmodule

bind pcs_loopback pcs_loopback_assert pcs_loopback_assert_i (
	.i_clk       (i_clk),
	.i_reset_n   (i_reset_n),
	.i_rx_status (o_rx_status),
	.i_rx_block  (rx_block)
);

`default_nettype wire

/* design/pcs_loopback.sv */
// PCS loopback top: framer, scrambler, fault injection, descrambler and block lock
`timescale 1ns/100ps
`default_nettype none

module pcs_loopback
	import pcs_pkg::*;
#(
	parameter int LOCK_GOOD = 64,
	parameter int BAD_LIMIT = 16
)
(
	input  wire              i_clk,
	input  wire              i_reset_n,

	// Transmit side
	input  wire pcs_word_t   i_tx_data,
	input  wire              i_tx_ctrl,

	// Per block bit flips on the line
	input  wire pcs_block_t  i_fault_mask,

	// Receive side, 4 clocks after transmit
	output pcs_word_t        o_rx_data,
	output rx_status_t       o_rx_status
);

	// Block at each stage
	pcs_block_t tx_block;
	pcs_block_t line_block;
	pcs_block_t rx_line;
	pcs_block_t rx_block;

	////////////////////////////////////////////////////////////
	// Transmit
	////////////////////////////////////////////////////////////

	pcs_block_framer pcs_block_framer_i (
		.i_clk     (i_clk),
		.i_reset_n (i_reset_n),
		.i_data    (i_tx_data),
		.i_ctrl    (i_tx_ctrl),
		.o_block   (tx_block)
	);

	pcs_scrambler #(.OPT_RX(1'b0)) pcs_scrambler_tx_i (
		.i_clk     (i_clk),
		.i_reset_n (i_reset_n),
		.i_block   (tx_block),
		.o_block   (line_block)
	);

	// Fault point, mask lines up with the word from 2 clocks earlier
	assign rx_line = line_block ^ i_fault_mask;

	////////////////////////////////////////////////////////////
	// Receive
	////////////////////////////////////////////////////////////

	pcs_scrambler #(.OPT_RX(1'b1)) pcs_scrambler_rx_i (
		.i_clk     (i_clk),
		.i_reset_n (i_reset_n),
		.i_block   (rx_line),
		.o_block   (rx_block)
	);

	pcs_block_lock #(
		.LOCK_GOOD (LOCK_GOOD),
		.BAD_LIMIT (BAD_LIMIT)
	) pcs_block_lock_i (
		.i_clk     (i_clk),
		.i_reset_n (i_reset_n),
		.i_block   (rx_block),
		.o_data    (o_rx_data),
		.o_status  (o_rx_status)
	);

endmodule

`default_nettype wire

/* design/pcs_block_lock.sv */
// Sync header checker, block lock FSM and receive unframing into payload and status
`timescale 1ns/100ps
`default_nettype none

module pcs_block_lock
	import pcs_pkg::*;
#(
	// Consecutive good headers needed to lock
	parameter int LOCK_GOOD = 64,
	// Bad headers in one window that drop lock
	parameter int BAD_LIMIT = 16
)
(
	// Clock and synchronous reset
	input  wire              i_clk,
	input  wire              i_reset_n,

	// Descrambled block
	input  wire pcs_block_t  i_block,

	// Unframed payload and block status
	output pcs_word_t        o_data,
	output rx_status_t       o_status
);

	////////////////////////////////////////////////////////////
	// Counter sizes
	////////////////////////////////////////////////////////////

	localparam int WIN_LEN = 64;
	localparam int GW      = $clog2(LOCK_GOOD + 1);
	localparam int BW      = $clog2(BAD_LIMIT + 1);
	localparam int WW      = $clog2(WIN_LEN);

	// Header of the current block
	pcs_hdr_t hdr;
	logic     hdr_ok;

	// FSM and counters
	lock_state_t    state, state_nxt;
	logic [GW-1:0]  good_cnt, good_nxt;
	logic [WW-1:0]  win_cnt, win_nxt;
	logic [BW-1:0]  bad_cnt, bad_nxt;

	// Status for this block
	rx_status_t status_nxt;

	// Only 01 and 10 are legal
	assign hdr    = i_block[HDR_BITS-1:0];
	assign hdr_ok = (hdr == SYNC_DATA) || (hdr == SYNC_CTRL);

	////////////////////////////////////////////////////////////
	// Lock FSM
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		good_nxt  = good_cnt;
		win_nxt   = win_cnt;
		bad_nxt   = bad_cnt;
		case (state)
		LOCK_RESET:
		begin
			// First block only opens the hunt
			state_nxt = LOCK_HUNT;
			good_nxt  = '0;
			win_nxt   = '0;
			bad_nxt   = '0;
		end
		LOCK_HUNT:
		begin
			// Fixed boundary, so just count clean headers in a row
			if (!hdr_ok)
				good_nxt = '0;
			else if (good_cnt == GW'(LOCK_GOOD - 1))
			begin
				state_nxt = LOCK_LOCKED;
				good_nxt  = '0;
				win_nxt   = '0;
				bad_nxt   = '0;
			end
			else
				good_nxt = good_cnt + 1'b1;
		end
		default:
		begin
			// LOCKED with a clean window, TEST once a bad header was seen
			win_nxt = win_cnt + 1'b1;
			if (!hdr_ok && (bad_cnt == BW'(BAD_LIMIT - 1)))
			begin
				// Too many errors in this window
				state_nxt = LOCK_HUNT;
				good_nxt  = '0;
				win_nxt   = '0;
				bad_nxt   = '0;
			end
			else if (win_cnt == WW'(WIN_LEN - 1))
			begin
				// Window closed under the limit
				state_nxt = LOCK_LOCKED;
				bad_nxt   = '0;
			end
			else if (!hdr_ok)
			begin
				state_nxt = LOCK_TEST;
				bad_nxt   = bad_cnt + 1'b1;
			end
		end
		endcase
	end

	// Status follows the state after this block
	always_comb
	begin
		status_nxt.ctrl    = (hdr == SYNC_CTRL);
		status_nxt.hdr_err = !hdr_ok;
		status_nxt.lock    = (state_nxt == LOCK_LOCKED) || (state_nxt == LOCK_TEST);
		status_nxt.valid   = status_nxt.lock && hdr_ok;
	end

	////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////

	// Payload and status leave together
	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
		begin
			state    <= LOCK_RESET;
			good_cnt <= '0;
			win_cnt  <= '0;
			bad_cnt  <= '0;
			o_data   <= '0;
			o_status <= '0;
		end
		else
		begin
			state    <= state_nxt;
			good_cnt <= good_nxt;
			win_cnt  <= win_nxt;
			bad_cnt  <= bad_nxt;
			o_data   <= i_block[BLOCK_BITS-1:HDR_BITS];
			o_status <= status_nxt;
		end
	end

endmodule

`default_nettype wire

/* design/pcs_scrambler.sv */
// Self-synchronizing 64b/66b scrambler over the block payload, transmit or receive form
`timescale 1ns/100ps
`default_nettype none

module pcs_scrambler
	import pcs_pkg::*;
#(
	// 0 scrambles for transmit, 1 descrambles on receive
	parameter bit OPT_RX = 1'b0
)
(
	// Clock and synchronous reset
	input  wire              i_clk,
	input  wire              i_reset_n,

	// Block in, header in bits 1:0
	input  wire pcs_block_t  i_block,

	// Block out, one clock later
	output pcs_block_t       o_block
);

	////////////////////////////////////////////////////////////
	// State
	////////////////////////////////////////////////////////////

	// Last 58 line bits, newest in bit 0
	pcs_fill_t fill;

	// Fill after all 64 payload bits of this block
	pcs_fill_t fill_nxt;

	// Block after scrambling
	pcs_block_t scr_block;

	////////////////////////////////////////////////////////////
	// Bit serial update, unrolled across the block
	////////////////////////////////////////////////////////////

	// Header bits pass through untouched
	// Each payload bit XORs with taps 39 and 58 bits back
	// The fill always takes the line side bit, so the receiver
	// realigns itself after 58 clean bits
	always_comb
	begin
		fill_nxt  = fill;
		scr_block = i_block;
		for (int k = HDR_BITS; k < BLOCK_BITS; k++)
		begin
			scr_block[k] = i_block[k] ^ (^(fill_nxt & SCR_POLY));
			if (OPT_RX)
				fill_nxt = {fill_nxt[SCR_BITS-2:0], i_block[k]};
			else
				fill_nxt = {fill_nxt[SCR_BITS-2:0], scr_block[k]};
		end
	end

	////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////

	// Both ends start from a zero fill
	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
		begin
			fill    <= '0;
			o_block <= '0;
		end
		else
		begin
			fill    <= fill_nxt;
			o_block <= scr_block;
		end
	end

endmodule

`default_nettype wire

/* design/pcs_block_framer.sv */
// Transmit block framer: word and control flag into a 66-bit block with sync header
`timescale 1ns/100ps
`default_nettype none

module pcs_block_framer
	import pcs_pkg::*;
(
	// Clock and synchronous reset
	input  wire             i_clk,
	input  wire             i_reset_n,

	// Transmit word and its control flag
	input  wire pcs_word_t  i_data,
	input  wire             i_ctrl,

	// Framed block toward the scrambler
	output pcs_block_t      o_block
);

	////////////////////////////////////////////////////////////
	// Header selection
	////////////////////////////////////////////////////////////

	// Sync header for this word
	pcs_hdr_t hdr_sel;

	// Block as it will be registered
	pcs_block_t block_nxt;

	// Control blocks get 10, data blocks get 01
	// Control payload is carried as is, no character encoding
	always_comb
	begin
		if (i_ctrl)
			hdr_sel = SYNC_CTRL;
		else
			hdr_sel = SYNC_DATA;
	end

	// Payload sits above the header
	// Header bit 0 is the first bit on the line
	always_comb
	begin
		block_nxt = {i_data, hdr_sel};
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	// One block per clock, no handshake
	// Zero after reset, which downstream reads as a bad header
	always_ff @(posedge i_clk)
	begin
		if (!i_reset_n)
		begin
			o_block <= '0;
		end
		else
		begin
			o_block <= block_nxt;
		end
	end

endmodule

`default_nettype wire

/* design/pcs_pkg.sv */
// PCS package: block and word types, sync headers, scrambler taps, lock states, rx status
`default_nettype none

package pcs_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int WORD_BITS  = 64;
	localparam int BLOCK_BITS = 66;
	localparam int HDR_BITS   = 2;

	// Payload word, one block of data
	typedef logic [WORD_BITS-1:0] pcs_word_t;

	// Line block, bit 0 goes on the wire first
	// Bits 1:0 sync header, bits 65:2 payload
	typedef logic [BLOCK_BITS-1:0] pcs_block_t;

	// Two bit sync header
	typedef logic [HDR_BITS-1:0] pcs_hdr_t;

	// Valid headers, the other two codes are errors
	localparam pcs_hdr_t SYNC_DATA = 2'b01;
	localparam pcs_hdr_t SYNC_CTRL = 2'b10;

	////////////////////////////////////////////////////////////
	// Scrambler, 1 + x^39 + x^58
	////////////////////////////////////////////////////////////

	localparam int SCR_BITS = 58;

	typedef logic [SCR_BITS-1:0] pcs_fill_t;

	// Taps at fill bits 38 and 57
	localparam pcs_fill_t SCR_POLY = (pcs_fill_t'(1) << 57) | (pcs_fill_t'(1) << 38);

	////////////////////////////////////////////////////////////
	// Receive side
	////////////////////////////////////////////////////////////

	// Block lock FSM
	typedef enum logic [1:0] {
		LOCK_RESET  = 2'd0,
		LOCK_HUNT   = 2'd1,
		LOCK_LOCKED = 2'd2,
		LOCK_TEST   = 2'd3
	} lock_state_t;

	// Per block receive status
	typedef struct packed {
		logic ctrl;
		logic valid;
		logic hdr_err;
		logic lock;
	} rx_status_t;

endpackage

`default_nettype wire
